//--- edge_dot_unit.sv
`timescale 1ns/1ps

module edge_dot_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dot_en,
    input  logic                     denom_en,

    input  raster_pkg::coord_q16_3_t e0x,
    input  raster_pkg::coord_q16_3_t e0y,
    input  raster_pkg::coord_q16_3_t e1x,
    input  raster_pkg::coord_q16_3_t e1y,

    output raster_pkg::dot_q32_6_t   d00,
    output raster_pkg::dot_q32_6_t   d01,
    output raster_pkg::dot_q32_6_t   d11,
    output logic                     denom_neg,
    output logic                     degenerate,
    output logic [63:0]              denom_mag
);

    raster_pkg::dot_q32_6_t d00_c;
    raster_pkg::dot_q32_6_t d01_c;
    raster_pkg::dot_q32_6_t d11_c;
    raster_pkg::denom_t     denom_c;
    logic [75:0]            denom_abs;
    logic [63:0]            mag_c;

    always_comb begin
        d00_c = e0x * e0x + e0y * e0y;
        d01_c = e0x * e1x + e0y * e1y;
        d11_c = e1x * e1x + e1y * e1y;
    end

    // Q64.12 denominator, magnitude reduced to its integer part
    always_comb begin
        denom_c   = d00 * d11 - d01 * d01;
        denom_abs = denom_c[75] ? 76'(-denom_c) : 76'(denom_c);
        mag_c     = denom_abs[75:12];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d00        <= '0;
            d01        <= '0;
            d11        <= '0;
            denom_neg  <= 1'b0;
            degenerate <= 1'b0;
            denom_mag  <= '0;
        end else begin
            if (dot_en) begin
                d00 <= d00_c;
                d01 <= d01_c;
                d11 <= d11_c;
            end
            if (denom_en) begin
                denom_neg  <= denom_c[75];
                degenerate <= (mag_c == '0);
                denom_mag  <= mag_c;
            end
        end
    end

endmodule

//--- filelist.f
raster_pkg.sv
setup_ctrl.sv
vertex_capture.sv
edge_dot_unit.sv
recip_divider.sv
triangle_setup.sv
tb_triangle_setup.sv

//--- raster_pkg.sv
package raster_pkg;

    // Screen used for bounding box clamping
    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;

    // Reciprocal divider
    localparam int DIV_STEPS = 17;
    localparam int RECIP_ONE = 65536;

    // Q16.16 input coordinate
    typedef logic signed [31:0] coord_q16_16_t;

    // Q16.3, top 19 bits of a Q16.16 value
    typedef logic signed [18:0] coord_q16_3_t;

    // Q32.6 product of two Q16.3 values
    typedef logic signed [37:0] dot_q32_6_t;

    // Q64.12 barycentric denominator
    typedef logic signed [75:0] denom_t;

    typedef logic [15:0] pix_t;
    typedef logic [23:0] color_t;

    // Q0.16
    typedef logic [15:0] recip_t;

    typedef struct packed {
        coord_q16_16_t x;
        coord_q16_16_t y;
        coord_q16_16_t z;
    } position_t;

    typedef struct packed {
        position_t pos;
        color_t    color;
    } vertex_t;

    typedef struct packed {
        pix_t          bbox_min_x;
        pix_t          bbox_max_x;
        pix_t          bbox_min_y;
        pix_t          bbox_max_y;
        coord_q16_3_t  v0x;
        coord_q16_3_t  v0y;
        coord_q16_3_t  e0x;
        coord_q16_3_t  e0y;
        coord_q16_3_t  e1x;
        coord_q16_3_t  e1y;
        dot_q32_6_t    d00;
        dot_q32_6_t    d01;
        dot_q32_6_t    d11;
        logic          denom_neg;
        logic          degenerate;
        recip_t        denom_inv;
        color_t        v0_color;
        color_t        v1_color;
        color_t        v2_color;
        coord_q16_16_t v0_depth;
        coord_q16_16_t v1_depth;
        coord_q16_16_t v2_depth;
    } tri_setup_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DOT,
        S_DENOM,
        S_DIV,
        S_OUTPUT
    } setup_state_t;

endpackage

//--- recip_divider.sv
`timescale 1ns/1ps

module recip_divider (
    input  logic               clk,
    input  logic               rst,
    input  logic               div_start,
    input  logic [63:0]        denom_mag,
    output raster_pkg::recip_t recip,
    output logic               div_by_zero,
    output logic               div_done
);

    logic [$clog2(raster_pkg::DIV_STEPS)-1:0] step_cnt;
    logic                                     active;

    // Dividend bits shift out of the top as quotient bits enter below
    logic [raster_pkg::DIV_STEPS-1:0] quo;
    logic [raster_pkg::DIV_STEPS-1:0] quo_next;
    logic [63:0]                      rem;
    logic [63:0]                      rem_next;
    logic [64:0]                      trial;
    logic                             fits;

    always_comb begin
        trial = {rem, quo[raster_pkg::DIV_STEPS-1]};
        fits  = (trial >= {1'b0, denom_mag});
        if (fits) begin
            rem_next = 64'(trial - {1'b0, denom_mag});
        end else begin
            rem_next = trial[63:0];
        end
        quo_next = {quo[raster_pkg::DIV_STEPS-2:0], fits};
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            quo <= raster_pkg::RECIP_ONE[raster_pkg::DIV_STEPS-1:0];
            rem <= '0;
        end else if (active) begin
            quo <= quo_next;
            rem <= rem_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active      <= 1'b0;
            step_cnt    <= '0;
            div_done    <= 1'b0;
            div_by_zero <= 1'b0;
            recip       <= '0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                active   <= 1'b1;
                step_cnt <= '0;
            end else if (active) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == raster_pkg::DIV_STEPS - 1) begin
                    active      <= 1'b0;
                    div_done    <= 1'b1;
                    div_by_zero <= (denom_mag == '0);
                    // Saturate at 65535, zero divisor gives 0
                    if (denom_mag == '0) begin
                        recip <= '0;
                    end else if (quo_next[raster_pkg::DIV_STEPS-1]) begin
                        recip <= '1;
                    end else begin
                        recip <= quo_next[15:0];
                    end
                end
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the triangle setup testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_triangle_setup -f filelist.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_triangle_setup > sim.log 2>&1 ; cat sim.log

grep -qx "RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- setup_ctrl.sv
`timescale 1ns/1ps

module setup_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    input  logic out_ready,
    input  logic div_done,

    output logic in_ready,
    output logic out_valid,
    output logic busy,

    output logic capture_en,
    output logic dot_en,
    output logic denom_en,
    output logic div_start
);

    raster_pkg::setup_state_t state;
    raster_pkg::setup_state_t next_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= raster_pkg::S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            raster_pkg::S_IDLE: begin
                if (in_valid) begin
                    next_state = raster_pkg::S_DOT;
                end
            end
            raster_pkg::S_DOT: begin
                next_state = raster_pkg::S_DENOM;
            end
            raster_pkg::S_DENOM: begin
                next_state = raster_pkg::S_DIV;
            end
            raster_pkg::S_DIV: begin
                if (div_done) begin
                    next_state = raster_pkg::S_OUTPUT;
                end
            end
            raster_pkg::S_OUTPUT: begin
                // Hold the record until the consumer takes it
                if (out_ready) begin
                    next_state = raster_pkg::S_IDLE;
                end
            end
            default: begin
                next_state = raster_pkg::S_IDLE;
            end
        endcase
    end

    assign in_ready  = (state == raster_pkg::S_IDLE);
    assign out_valid = (state == raster_pkg::S_OUTPUT);
    assign busy      = (state != raster_pkg::S_IDLE);

    assign capture_en = in_valid && in_ready;
    assign dot_en     = (state == raster_pkg::S_DOT);
    assign denom_en   = (state == raster_pkg::S_DENOM);

    // Divider loads on the edge that enters S_DIV and starts
    // stepping once the denominator register is settled
    assign div_start = (state == raster_pkg::S_DENOM);

endmodule

//--- tb_triangle_setup.sv
`timescale 1ns/1ps

module tb_triangle_setup;

    localparam int TIMEOUT = 100;
    localparam int LATENCY = 20;
    localparam int N_ROWS  = 11;
    localparam int N_RAND  = 20;

    logic clk = 1'b0;
    logic rst;
    raster_pkg::vertex_t    v0;
    raster_pkg::vertex_t    v1;
    raster_pkg::vertex_t    v2;
    logic                   in_valid;
    logic                   in_ready;
    raster_pkg::tri_setup_t out_state;
    logic                   out_valid;
    logic                   out_ready;
    logic                   busy;

    // Stimulus table with the hand-derived degenerate flag
    string               row_name  [N_ROWS];
    raster_pkg::vertex_t row_a     [N_ROWS];
    raster_pkg::vertex_t row_b     [N_ROWS];
    raster_pkg::vertex_t row_c     [N_ROWS];
    logic                row_degen [N_ROWS];

    string cur_name;
    int    err_count = 0;
    int    test_errs = 0;
    int    tests_run = 0;
    int    passed    = 0;
    int    failed    = 0;
    logic  timed_out = 1'b0;

    triangle_setup dut0 (
        .clk       (clk),
        .rst       (rst),
        .v0        (v0),
        .v1        (v1),
        .v2        (v2),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_state (out_state),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy)
    );

    always #4 clk = ~clk;

    function automatic int px(input int whole);
        return whole * 65536;
    endfunction

    function automatic int fx(input int whole, input int frac);
        return whole * 65536 + frac;
    endfunction

    function automatic raster_pkg::vertex_t make_vertex(input int x, input int y, input int z,
                                                        input raster_pkg::color_t color);
        raster_pkg::vertex_t v;
        v.pos.x = x;
        v.pos.y = y;
        v.pos.z = z;
        v.color = color;
        return v;
    endfunction

    function automatic raster_pkg::vertex_t random_vertex();
        int x;
        int y;
        x = fx(int'($urandom_range(0, 511)) - 64, int'($urandom_range(0, 65535)));
        y = fx(int'($urandom_range(0, 511)) - 64, int'($urandom_range(0, 65535)));
        return make_vertex(x, y, int'($urandom()), raster_pkg::color_t'($urandom()));
    endfunction

    function automatic int clamp_to_screen(input int v, input int limit);
        if (v < 0) begin
            return 0;
        end
        return (v > limit - 1) ? limit - 1 : v;
    endfunction

    // Reference model of the setup record
    function automatic raster_pkg::tri_setup_t expected_record(input raster_pkg::vertex_t a,
                                                               input raster_pkg::vertex_t b,
                                                               input raster_pkg::vertex_t c);
        raster_pkg::tri_setup_t r;
        raster_pkg::vertex_t    vs [3];
        int                     ix [3];
        int                     iy [3];
        int                     qx [3];
        int                     qy [3];
        int                     lo_x;
        int                     hi_x;
        int                     lo_y;
        int                     hi_y;
        longint                 ex0;
        longint                 ey0;
        longint                 ex1;
        longint                 ey1;
        logic signed [127:0]    s00;
        logic signed [127:0]    s01;
        logic signed [127:0]    s11;
        logic signed [127:0]    den;
        logic signed [127:0]    den_abs;
        logic [63:0]            mag;
        logic [63:0]            q;
        vs[0] = a;
        vs[1] = b;
        vs[2] = c;
        for (int k = 0; k < 3; k++) begin
            ix[k] = $signed(vs[k].pos.x) >>> 16;
            iy[k] = $signed(vs[k].pos.y) >>> 16;
            qx[k] = $signed(vs[k].pos.x) >>> 13;
            qy[k] = $signed(vs[k].pos.y) >>> 13;
        end
        lo_x = ix[0];
        hi_x = ix[0];
        lo_y = iy[0];
        hi_y = iy[0];
        for (int k = 1; k < 3; k++) begin
            lo_x = (ix[k] < lo_x) ? ix[k] : lo_x;
            hi_x = (ix[k] > hi_x) ? ix[k] : hi_x;
            lo_y = (iy[k] < lo_y) ? iy[k] : lo_y;
            hi_y = (iy[k] > hi_y) ? iy[k] : hi_y;
        end
        r.bbox_min_x = raster_pkg::pix_t'(clamp_to_screen(lo_x, raster_pkg::SCREEN_W));
        r.bbox_max_x = raster_pkg::pix_t'(clamp_to_screen(hi_x, raster_pkg::SCREEN_W));
        r.bbox_min_y = raster_pkg::pix_t'(clamp_to_screen(lo_y, raster_pkg::SCREEN_H));
        r.bbox_max_y = raster_pkg::pix_t'(clamp_to_screen(hi_y, raster_pkg::SCREEN_H));
        ex0 = qx[1] - qx[0];
        ey0 = qy[1] - qy[0];
        ex1 = qx[2] - qx[0];
        ey1 = qy[2] - qy[0];
        r.v0x = raster_pkg::coord_q16_3_t'(qx[0]);
        r.v0y = raster_pkg::coord_q16_3_t'(qy[0]);
        r.e0x = raster_pkg::coord_q16_3_t'(ex0);
        r.e0y = raster_pkg::coord_q16_3_t'(ey0);
        r.e1x = raster_pkg::coord_q16_3_t'(ex1);
        r.e1y = raster_pkg::coord_q16_3_t'(ey1);
        s00 = ex0 * ex0 + ey0 * ey0;
        s01 = ex0 * ex1 + ey0 * ey1;
        s11 = ex1 * ex1 + ey1 * ey1;
        r.d00 = raster_pkg::dot_q32_6_t'(s00);
        r.d01 = raster_pkg::dot_q32_6_t'(s01);
        r.d11 = raster_pkg::dot_q32_6_t'(s11);
        den     = s00 * s11 - s01 * s01;
        den_abs = (den < 0) ? -den : den;
        mag     = den_abs[75:12];
        r.denom_neg  = (den < 0);
        r.degenerate = (mag == 0);
        q = (mag == 0) ? 64'd0 : 64'(raster_pkg::RECIP_ONE) / mag;
        r.denom_inv  = (q > 65535) ? 16'hffff : q[15:0];
        r.v0_color = a.color;
        r.v1_color = b.color;
        r.v2_color = c.color;
        r.v0_depth = a.pos.z;
        r.v1_depth = b.pos.z;
        r.v2_depth = c.pos.z;
        return r;
    endfunction

    task automatic add_row(input int i, input string n, input int x0, input int y0,
                           input int x1, input int y1, input int x2, input int y2,
                           input logic degen);
        row_name[i]  = n;
        row_a[i]     = make_vertex(x0, y0, -(i * 65536 + 100), 24'hff0000 ^ 24'(i));
        row_b[i]     = make_vertex(x1, y1, i * 65536 + 200, 24'h00ff00 ^ 24'(i << 8));
        row_c[i]     = make_vertex(x2, y2, 32'h7fff0000 - i, 24'h0000ff ^ 24'(i << 16));
        row_degen[i] = degen;
    endtask

    task automatic load_table();
        add_row(0, "interior_ccw", px(10), px(10), px(50), px(10), px(10), px(40), 0);
        add_row(1, "interior_cw", px(10), px(10), px(10), px(40), px(50), px(10), 0);
        add_row(2, "frac_coords", fx(20, 16'h4321), fx(30, 16'hb0f0),
                fx(70, 16'h8fff), fx(35, 16'h2001), fx(40, 16'he123), fx(90, 16'h5555), 0);
        add_row(3, "off_right_bottom", px(300), px(200), px(400), px(220), px(310), px(300), 0);
        add_row(4, "negative_coords", px(-20), px(-5), px(30), px(-40), fx(-1, 16'h8000),
                px(25), 0);
        add_row(5, "fully_offscreen", px(-100), px(-100), px(-50), px(-80), px(-90), px(-20), 0);
        add_row(6, "collinear", px(0), px(0), px(10), px(10), px(20), px(20), 1);
        add_row(7, "coincident", px(5), px(5), px(5), px(5), px(5), px(5), 1);
        // One pixel legs give denom_mag of 1, so the reciprocal saturates
        add_row(8, "unit_pixel", px(100), px(100), px(101), px(100), px(100), px(101), 0);
        add_row(9, "full_screen", px(0), px(0), px(319), px(0), px(0), px(239), 0);
        add_row(10, "subpixel_sliver", px(50), px(50), fx(50, 16'h2000), px(50),
                px(50), fx(50, 16'h2000), 1);
    endtask

    task automatic check_value(input string field, input logic [511:0] expected,
                               input logic [511:0] actual);
        assert (expected === actual) else begin
            $display("CHECK FAILED %s %s: expected %0h actual %0h",
                     cur_name, field, expected, actual);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic drive_triangle(input raster_pkg::vertex_t a, input raster_pkg::vertex_t b,
                                  input raster_pkg::vertex_t c);
        int waited;
        waited = 0;
        @(posedge clk);
        v0       <= a;
        v1       <= b;
        v2       <= c;
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!in_ready) begin
            $display("Timeout in %s: in_ready stayed low for %0d cycles", cur_name, TIMEOUT);
            timed_out = 1'b1;
        end else begin
            // Accepting edge, then the source drops its vertices
            @(posedge clk);
            in_valid <= 1'b0;
            v0       <= random_vertex();
            v1       <= random_vertex();
            v2       <= random_vertex();
        end
    endtask

    task automatic wait_for_output(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!out_valid && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (!out_valid) begin
            $display("Timeout in %s: out_valid did not rise within %0d cycles",
                     cur_name, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic hold_output(input int stall);
        raster_pkg::tri_setup_t held;
        held = out_state;
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            check_value("stable_record", held, out_state);
            check_value("in_ready_held", 1'b0, in_ready);
            check_value("busy_held", 1'b1, busy);
            check_value("out_valid_held", 1'b1, out_valid);
        end
    endtask

    task automatic release_output();
        @(posedge clk);
        out_ready <= 1'b1;
        @(posedge clk);
        out_ready <= 1'b0;
        @(negedge clk);
        check_value("in_ready_after_release", 1'b1, in_ready);
        check_value("out_valid_after_release", 1'b0, out_valid);
        check_value("busy_after_release", 1'b0, busy);
    endtask

    task automatic run_one(input string name, input raster_pkg::vertex_t a,
                           input raster_pkg::vertex_t b, input raster_pkg::vertex_t c,
                           input logic use_row, input logic row_deg);
        raster_pkg::tri_setup_t model;
        raster_pkg::tri_setup_t got;
        int                     latency;
        cur_name  = name;
        test_errs = 0;
        model = expected_record(a, b, c);
        drive_triangle(a, b, c);
        if (!timed_out) begin
            wait_for_output(latency);
        end
        if (!timed_out) begin
            got = out_state;
            check_value("latency", LATENCY, latency);
            check_value("bbox", {model.bbox_min_x, model.bbox_max_x, model.bbox_min_y,
                        model.bbox_max_y}, {got.bbox_min_x, got.bbox_max_x, got.bbox_min_y,
                        got.bbox_max_y});
            check_value("v0", {model.v0x, model.v0y}, {got.v0x, got.v0y});
            check_value("edges", {model.e0x, model.e0y, model.e1x, model.e1y},
                        {got.e0x, got.e0y, got.e1x, got.e1y});
            check_value("dots", {model.d00, model.d01, model.d11}, {got.d00, got.d01, got.d11});
            check_value("denom_neg", model.denom_neg, got.denom_neg);
            check_value("degenerate", model.degenerate, got.degenerate);
            check_value("denom_inv", model.denom_inv, got.denom_inv);
            check_value("colors", {model.v0_color, model.v1_color, model.v2_color},
                        {got.v0_color, got.v1_color, got.v2_color});
            check_value("depths", {model.v0_depth, model.v1_depth, model.v2_depth},
                        {got.v0_depth, got.v1_depth, got.v2_depth});
            if (use_row) begin
                check_value("table_degenerate", row_deg, got.degenerate);
                // Lagrange identity keeps the exact denominator non-negative
                check_value("table_denom_neg", 1'b0, got.denom_neg);
            end
            check_value("in_ready_on_output", 1'b0, in_ready);
            check_value("busy_on_output", 1'b1, busy);
            hold_output(int'($urandom_range(0, 6)));
            release_output();
        end
        tests_run++;
        if (test_errs == 0 && !timed_out) begin
            passed++;
            $display("test %s ok", name);
        end else begin
            failed++;
            $display("test %s failed with %0d check errors", name, test_errs);
        end
    endtask

    initial begin
        raster_pkg::vertex_t ra;
        raster_pkg::vertex_t rb;
        raster_pkg::vertex_t rc;
        void'($urandom(29492));
        rst       = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        v0        = '0;
        v1        = '0;
        v2        = '0;
        load_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        cur_name  = "reset";
        test_errs = 0;
        check_value("in_ready", 1'b1, in_ready);
        check_value("out_valid", 1'b0, out_valid);
        check_value("busy", 1'b0, busy);
        check_value("div_start", 1'b0, dut0.div_start);
        check_value("div_done", 1'b0, dut0.div_done);
        tests_run++;
        if (test_errs == 0) begin
            passed++;
            $display("test reset ok");
        end else begin
            failed++;
            $display("test reset failed with %0d check errors", test_errs);
        end

        for (int i = 0; i < N_ROWS; i++) begin
            if (!timed_out) begin
                run_one(row_name[i], row_a[i], row_b[i], row_c[i], 1'b1, row_degen[i]);
            end
        end
        for (int i = 0; i < N_RAND; i++) begin
            if (!timed_out) begin
                ra = random_vertex();
                rb = random_vertex();
                rc = random_vertex();
                run_one($sformatf("random_%0d", i), ra, rb, rc, 1'b0, 1'b0);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, checks failed %0d",
                 tests_run, passed, failed, err_count);
        if (err_count == 0 && failed == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- triangle_setup.sv
`timescale 1ns/1ps

module triangle_setup (
    input  logic                   clk,
    input  logic                   rst,

    input  raster_pkg::vertex_t    v0,
    input  raster_pkg::vertex_t    v1,
    input  raster_pkg::vertex_t    v2,
    input  logic                   in_valid,
    output logic                   in_ready,

    output raster_pkg::tri_setup_t out_state,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic                   busy
);

    logic capture_en;
    logic dot_en;
    logic denom_en;
    logic div_start;
    logic div_done;
    logic div_by_zero;

    raster_pkg::pix_t          bbox_min_x;
    raster_pkg::pix_t          bbox_max_x;
    raster_pkg::pix_t          bbox_min_y;
    raster_pkg::pix_t          bbox_max_y;
    raster_pkg::coord_q16_3_t  v0x;
    raster_pkg::coord_q16_3_t  v0y;
    raster_pkg::coord_q16_3_t  e0x;
    raster_pkg::coord_q16_3_t  e0y;
    raster_pkg::coord_q16_3_t  e1x;
    raster_pkg::coord_q16_3_t  e1y;
    raster_pkg::color_t        c0;
    raster_pkg::color_t        c1;
    raster_pkg::color_t        c2;
    raster_pkg::coord_q16_16_t z0;
    raster_pkg::coord_q16_16_t z1;
    raster_pkg::coord_q16_16_t z2;

    raster_pkg::dot_q32_6_t    d00;
    raster_pkg::dot_q32_6_t    d01;
    raster_pkg::dot_q32_6_t    d11;
    logic                      denom_neg;
    logic                      degenerate;
    logic [63:0]               denom_mag;

    raster_pkg::recip_t        recip;
    raster_pkg::recip_t        denom_inv;

    setup_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .out_ready  (out_ready),
        .div_done   (div_done),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .busy       (busy),
        .capture_en (capture_en),
        .dot_en     (dot_en),
        .denom_en   (denom_en),
        .div_start  (div_start)
    );

    vertex_capture u_capture (
        .clk        (clk),
        .rst        (rst),
        .capture_en (capture_en),
        .v0         (v0),
        .v1         (v1),
        .v2         (v2),
        .bbox_min_x (bbox_min_x),
        .bbox_max_x (bbox_max_x),
        .bbox_min_y (bbox_min_y),
        .bbox_max_y (bbox_max_y),
        .v0x        (v0x),
        .v0y        (v0y),
        .e0x        (e0x),
        .e0y        (e0y),
        .e1x        (e1x),
        .e1y        (e1y),
        .c0         (c0),
        .c1         (c1),
        .c2         (c2),
        .z0         (z0),
        .z1         (z1),
        .z2         (z2)
    );

    edge_dot_unit u_dot (
        .clk        (clk),
        .rst        (rst),
        .dot_en     (dot_en),
        .denom_en   (denom_en),
        .e0x        (e0x),
        .e0y        (e0y),
        .e1x        (e1x),
        .e1y        (e1y),
        .d00        (d00),
        .d01        (d01),
        .d11        (d11),
        .denom_neg  (denom_neg),
        .degenerate (degenerate),
        .denom_mag  (denom_mag)
    );

    recip_divider u_div (
        .clk         (clk),
        .rst         (rst),
        .div_start   (div_start),
        .denom_mag   (denom_mag),
        .recip       (recip),
        .div_by_zero (div_by_zero),
        .div_done    (div_done)
    );

    // Held across back-pressure, reloaded only by the next division
    always_ff @(posedge clk) begin
        if (div_done) begin
            denom_inv <= div_by_zero ? '0 : recip;
        end
    end

    always_comb begin
        out_state.bbox_min_x = bbox_min_x;
        out_state.bbox_max_x = bbox_max_x;
        out_state.bbox_min_y = bbox_min_y;
        out_state.bbox_max_y = bbox_max_y;
        out_state.v0x        = v0x;
        out_state.v0y        = v0y;
        out_state.e0x        = e0x;
        out_state.e0y        = e0y;
        out_state.e1x        = e1x;
        out_state.e1y        = e1y;
        out_state.d00        = d00;
        out_state.d01        = d01;
        out_state.d11        = d11;
        out_state.denom_neg  = denom_neg;
        out_state.degenerate = degenerate;
        out_state.denom_inv  = denom_inv;
        out_state.v0_color   = c0;
        out_state.v1_color   = c1;
        out_state.v2_color   = c2;
        out_state.v0_depth   = z0;
        out_state.v1_depth   = z1;
        out_state.v2_depth   = z2;
    end

endmodule

//--- vertex_capture.sv
`timescale 1ns/1ps

module vertex_capture (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      capture_en,

    input  raster_pkg::vertex_t       v0,
    input  raster_pkg::vertex_t       v1,
    input  raster_pkg::vertex_t       v2,

    output raster_pkg::pix_t          bbox_min_x,
    output raster_pkg::pix_t          bbox_max_x,
    output raster_pkg::pix_t          bbox_min_y,
    output raster_pkg::pix_t          bbox_max_y,

    output raster_pkg::coord_q16_3_t  v0x,
    output raster_pkg::coord_q16_3_t  v0y,
    output raster_pkg::coord_q16_3_t  e0x,
    output raster_pkg::coord_q16_3_t  e0y,
    output raster_pkg::coord_q16_3_t  e1x,
    output raster_pkg::coord_q16_3_t  e1y,

    output raster_pkg::color_t        c0,
    output raster_pkg::color_t        c1,
    output raster_pkg::color_t        c2,
    output raster_pkg::coord_q16_16_t z0,
    output raster_pkg::coord_q16_16_t z1,
    output raster_pkg::coord_q16_16_t z2
);

    function automatic raster_pkg::coord_q16_16_t min3(
        input raster_pkg::coord_q16_16_t a,
        input raster_pkg::coord_q16_16_t b,
        input raster_pkg::coord_q16_16_t c
    );
        raster_pkg::coord_q16_16_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic raster_pkg::coord_q16_16_t max3(
        input raster_pkg::coord_q16_16_t a,
        input raster_pkg::coord_q16_16_t b,
        input raster_pkg::coord_q16_16_t c
    );
        raster_pkg::coord_q16_16_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Integer part, clamped to [0, limit-1]
    function automatic raster_pkg::pix_t clamp_pix(
        input raster_pkg::coord_q16_16_t v,
        input int                        limit
    );
        logic signed [15:0] ipart;
        ipart = v[31:16];
        if (ipart < 0) begin
            return '0;
        end
        if (ipart > limit - 1) begin
            return raster_pkg::pix_t'(limit - 1);
        end
        return raster_pkg::pix_t'(ipart);
    endfunction

    // Q16.16 to Q16.3 keeps the top 19 bits
    function automatic raster_pkg::coord_q16_3_t to_q16_3(input raster_pkg::coord_q16_16_t v);
        return v[31:13];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bbox_min_x <= '0;
            bbox_max_x <= '0;
            bbox_min_y <= '0;
            bbox_max_y <= '0;
            v0x        <= '0;
            v0y        <= '0;
            e0x        <= '0;
            e0y        <= '0;
            e1x        <= '0;
            e1y        <= '0;
        end else if (capture_en) begin
            // Box from the live inputs, source drops them after this edge
            bbox_min_x <= clamp_pix(min3(v0.pos.x, v1.pos.x, v2.pos.x), raster_pkg::SCREEN_W);
            bbox_max_x <= clamp_pix(max3(v0.pos.x, v1.pos.x, v2.pos.x), raster_pkg::SCREEN_W);
            bbox_min_y <= clamp_pix(min3(v0.pos.y, v1.pos.y, v2.pos.y), raster_pkg::SCREEN_H);
            bbox_max_y <= clamp_pix(max3(v0.pos.y, v1.pos.y, v2.pos.y), raster_pkg::SCREEN_H);
            v0x        <= to_q16_3(v0.pos.x);
            v0y        <= to_q16_3(v0.pos.y);
            e0x        <= to_q16_3(v1.pos.x) - to_q16_3(v0.pos.x);
            e0y        <= to_q16_3(v1.pos.y) - to_q16_3(v0.pos.y);
            e1x        <= to_q16_3(v2.pos.x) - to_q16_3(v0.pos.x);
            e1y        <= to_q16_3(v2.pos.y) - to_q16_3(v0.pos.y);
        end
    end

    // Pass-through attributes
    always_ff @(posedge clk) begin
        if (capture_en) begin
            c0 <= v0.color;
            c1 <= v1.color;
            c2 <= v2.color;
            z0 <= v0.pos.z;
            z1 <= v1.pos.z;
            z2 <= v2.pos.z;
        end
    end

endmodule
